//--- pe_config.svh
`ifndef PE_CONFIG_SVH
`define PE_CONFIG_SVH

// Element and partial-sum widths
`define PE_DATA_W 8
`define PE_PSUM_W 20

// Buffer depths and address widths
`define PE_IF_DEPTH 32
`define PE_IF_AW 5
`define PE_FILT_DEPTH 8
`define PE_FILT_AW 3
`define PE_OUT_DEPTH 32
`define PE_OUT_AW 5

// N and output count share one width, K has its own
`define PE_LEN_W 6
`define PE_KLEN_W 4

`define PE_WB_AW 8
`define PE_WB_DW 32

// Word offsets inside REG_SPACE
`define PE_REG_CTRL 6'd0
`define PE_REG_LEN 6'd1
`define PE_REG_STATUS 6'd2

`endif

//--- pe_pkg.sv
package pe_pkg;

    // Run controller states
    typedef enum logic [2:0] {
        ST_RESET    = 3'd0,
        ST_LOAD     = 3'd1,
        ST_DISPATCH = 3'd2,
        ST_CONV_S1  = 3'd3,
        ST_CONV_S2  = 3'd4,
        ST_ADD      = 3'd5,
        ST_DONE     = 3'd6
    } ctrl_state_t;

    typedef enum logic [1:0] {
        MODE_CONV_S1  = 2'd0,
        MODE_CONV_S2  = 2'd1,
        MODE_BIAS_ADD = 2'd2,
        MODE_BAD      = 2'd3  // Rejected at dispatch
    } conv_mode_t;

    // Top two bits of the word address
    typedef enum logic [1:0] {
        REG_SPACE  = 2'd0,
        IF_SPACE   = 2'd1,
        FILT_SPACE = 2'd2,
        OUT_SPACE  = 2'd3
    } wb_region_t;

endpackage

//--- pe_scratchpad.sv
`timescale 1ns/1ps

module pe_scratchpad #(
    parameter int DEPTH = 32,
    parameter int WIDTH = 8
) (
    input  logic                     clk,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] waddr,
    input  logic [WIDTH-1:0]         wdata,
    input  logic [$clog2(DEPTH)-1:0] raddr,
    output logic [WIDTH-1:0]         rdata
);

    logic [WIDTH-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        rdata <= mem[raddr]; // One cycle read latency
    end

endmodule

//--- pe_addr_gen.sv
`timescale 1ns/1ps
`include "pe_config.svh"

module pe_addr_gen (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   reset_all,
    input  logic                   read_start,
    input  logic                   start_rd_gen,
    input  pe_pkg::conv_mode_t     mode,
    input  logic [`PE_LEN_W-1:0]   if_len,
    input  logic [`PE_KLEN_W-1:0]  filt_len,
    output logic [`PE_IF_AW-1:0]   if_raddr,
    output logic [`PE_FILT_AW-1:0] filt_raddr,
    output logic                   tap_valid,
    output logic                   last_tap,
    output logic [`PE_OUT_AW-1:0]  out_idx,
    output logic [`PE_LEN_W-1:0]   out_count,
    output logic                   full_done
);

    pe_pkg::conv_mode_t          run_mode;
    logic [`PE_KLEN_W-1:0]       run_klen;
    logic [`PE_FILT_AW-1:0]      tap;
    logic [`PE_IF_AW-1:0]        tap_ext;
    logic [`PE_LEN_W-1:0]        klen_ext;
    logic [`PE_LEN_W-1:0]        span;
    logic [`PE_LEN_W-1:0]        count_next;
    logic                        active;
    logic                        last_out;

    assign klen_ext = {{(`PE_LEN_W-`PE_KLEN_W){1'b0}}, filt_len};
    assign span     = if_len - klen_ext;
    assign tap_ext  = {{(`PE_IF_AW-`PE_FILT_AW){1'b0}}, tap};

    // Output count from the live lengths
    always_comb begin
        if (mode == pe_pkg::MODE_BIAS_ADD) begin
            count_next = if_len;
        end else if (mode == pe_pkg::MODE_BAD || klen_ext > if_len) begin
            count_next = '0;
        end else if (mode == pe_pkg::MODE_CONV_S2) begin
            count_next = (span >> 1) + 1'b1; // floor((N-K)/2)+1
        end else begin
            count_next = span + 1'b1;
        end
    end

    assign tap_valid = active;
    assign last_tap  = active && (run_mode == pe_pkg::MODE_BIAS_ADD ||
                                  {1'b0, tap} == run_klen - 1'b1);
    assign last_out  = ({1'b0, out_idx} == out_count - 1'b1);

    always_comb begin
        case (run_mode)
            pe_pkg::MODE_CONV_S2:  if_raddr = {out_idx[`PE_OUT_AW-2:0], 1'b0} + tap_ext;
            pe_pkg::MODE_BIAS_ADD: if_raddr = out_idx;
            default:               if_raddr = out_idx + tap_ext;
        endcase
        filt_raddr = (run_mode == pe_pkg::MODE_BIAS_ADD) ? '0 : tap;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            run_mode  <= pe_pkg::MODE_CONV_S1;
            run_klen  <= '0;
            out_count <= '0;
            active    <= 1'b0;
            out_idx   <= '0;
            tap       <= '0;
            full_done <= 1'b0;
        end else if (reset_all) begin
            out_count <= '0;
            active    <= 1'b0;
            out_idx   <= '0;
            tap       <= '0;
            full_done <= 1'b0;
        end else begin
            full_done <= 1'b0;
            if (read_start) begin // Snapshot of the run setup
                run_mode  <= mode;
                run_klen  <= filt_len;
                out_count <= count_next;
            end
            if (start_rd_gen) begin
                active  <= 1'b1;
                out_idx <= '0;
                tap     <= '0;
            end else if (active) begin
                if (!last_tap) begin
                    tap <= tap + 1'b1;
                end else begin
                    tap <= '0;
                    if (last_out) begin
                        active    <= 1'b0;
                        full_done <= 1'b1; // One cycle after the last address
                    end else begin
                        out_idx <= out_idx + 1'b1;
                    end
                end
            end
        end
    end

endmodule

//--- pe_mac.sv
`timescale 1ns/1ps
`include "pe_config.svh"

module pe_mac (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         reset_all,
    input  logic                         clear_regs,
    input  pe_pkg::conv_mode_t           mode,
    input  logic                         tap_valid,
    input  logic                         last_tap,
    input  logic [`PE_OUT_AW-1:0]        out_idx,
    input  logic signed [`PE_DATA_W-1:0] if_data,
    input  logic signed [`PE_DATA_W-1:0] filt_data,
    output logic                         psum_done,
    output logic                         out_we,
    output logic [`PE_OUT_AW-1:0]        out_waddr,
    output logic signed [`PE_PSUM_W-1:0] out_wdata
);

    logic                         valid_d1;
    logic                         last_d1;
    logic                         valid_d2;
    logic                         last_d2;
    logic [`PE_OUT_AW-1:0]        idx_d1;
    logic [`PE_OUT_AW-1:0]        idx_d2;
    logic signed [`PE_PSUM_W-1:0] prod;
    logic signed [`PE_PSUM_W-1:0] acc;
    logic signed [`PE_PSUM_W-1:0] sum;

    // Address cycle, then read data, then product
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_d1 <= 1'b0;
            last_d1  <= 1'b0;
            valid_d2 <= 1'b0;
            last_d2  <= 1'b0;
        end else if (reset_all) begin
            valid_d1 <= 1'b0;
            last_d1  <= 1'b0;
            valid_d2 <= 1'b0;
            last_d2  <= 1'b0;
        end else begin
            valid_d1 <= tap_valid;
            last_d1  <= tap_valid && last_tap;
            valid_d2 <= valid_d1;
            last_d2  <= last_d1;
        end
    end

    always_ff @(posedge clk) begin
        idx_d1 <= out_idx;
        idx_d2 <= idx_d1;
        if (mode == pe_pkg::MODE_BIAS_ADD) begin
            prod <= if_data + filt_data;
        end else begin
            prod <= if_data * filt_data; // Sign extended to psum width
        end
        if (reset_all || clear_regs) begin
            acc <= '0;
        end else if (valid_d2) begin
            acc <= sum;
        end
    end

    assign sum       = acc + prod;
    assign psum_done = valid_d2 && last_d2;
    assign out_we    = psum_done;
    assign out_waddr = idx_d2;
    assign out_wdata = sum;   // Includes the last product

endmodule

//--- pe_controller.sv
`timescale 1ns/1ps

module pe_controller (
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    input  pe_pkg::conv_mode_t mode,
    input  logic               full_done,
    input  logic               psum_done,
    input  logic               empty_run,
    output logic               reset_all,
    output logic               read_start,
    output logic               start_rd_gen,
    output logic               clear_regs,
    output logic               busy,
    output logic               done,
    output logic               error
);

    pe_pkg::ctrl_state_t state;
    pe_pkg::ctrl_state_t state_next;
    logic                issued;   // Address generator already launched
    logic                bad_run;
    logic                working;

    assign bad_run = (mode == pe_pkg::MODE_BAD) || empty_run;
    assign working = (state == pe_pkg::ST_CONV_S1) || (state == pe_pkg::ST_CONV_S2) ||
                     (state == pe_pkg::ST_ADD);

    //////////////////////////////////////////////////////////////////////
    // State register, start wins from any state
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= pe_pkg::ST_RESET;
        end else if (start) begin
            state <= pe_pkg::ST_LOAD;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            issued <= 1'b0;
            error  <= 1'b0;
        end else if (start) begin
            issued <= 1'b0;
            error  <= 1'b0;
        end else if (state == pe_pkg::ST_DISPATCH && !issued) begin
            issued <= 1'b1;
            error  <= bad_run;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Next state
    always_comb begin
        state_next = state;
        case (state)
            pe_pkg::ST_RESET: state_next = pe_pkg::ST_RESET;
            pe_pkg::ST_LOAD:  state_next = pe_pkg::ST_DISPATCH;
            pe_pkg::ST_DISPATCH: begin
                if (!issued) begin
                    if (bad_run) begin
                        state_next = pe_pkg::ST_DONE;
                    end else if (mode == pe_pkg::MODE_CONV_S1) begin
                        state_next = pe_pkg::ST_CONV_S1;
                    end else if (mode == pe_pkg::MODE_CONV_S2) begin
                        state_next = pe_pkg::ST_CONV_S2;
                    end else begin
                        state_next = pe_pkg::ST_ADD;
                    end
                end else if (psum_done) begin
                    state_next = pe_pkg::ST_DONE; // Final sum written
                end
            end
            pe_pkg::ST_CONV_S1,
            pe_pkg::ST_CONV_S2,
            pe_pkg::ST_ADD: begin
                if (full_done) begin
                    state_next = pe_pkg::ST_DISPATCH;
                end
            end
            pe_pkg::ST_DONE: state_next = pe_pkg::ST_DONE;
            default:         state_next = pe_pkg::ST_RESET;
        endcase
    end

    assign reset_all    = (state == pe_pkg::ST_RESET) || start;
    assign read_start   = (state == pe_pkg::ST_LOAD);
    assign start_rd_gen = (state == pe_pkg::ST_DISPATCH) && !issued && !bad_run;
    assign clear_regs   = working && psum_done;
    assign busy         = (state != pe_pkg::ST_RESET) && (state != pe_pkg::ST_DONE);
    assign done         = (state == pe_pkg::ST_DONE);

endmodule

//--- pe_wb_regs.sv
`timescale 1ns/1ps
`include "pe_config.svh"

module pe_wb_regs (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   wb_cyc,
    input  logic                   wb_stb,
    input  logic                   wb_we,
    input  logic [`PE_WB_AW-1:0]   wb_adr,
    input  logic [`PE_WB_DW-1:0]   wb_dat_w,
    output logic [`PE_WB_DW-1:0]   wb_dat_r,
    output logic                   wb_ack,
    input  logic                   busy,
    input  logic                   done,
    input  logic                   error,
    input  logic [`PE_LEN_W-1:0]   out_count,
    input  logic [`PE_PSUM_W-1:0]  out_rdata,
    output logic                   start,
    output pe_pkg::conv_mode_t     mode,
    output logic [`PE_LEN_W-1:0]   if_len,
    output logic [`PE_KLEN_W-1:0]  filt_len,
    output logic                   if_we,
    output logic                   filt_we,
    output logic [`PE_IF_AW-1:0]   buf_waddr,
    output logic [`PE_DATA_W-1:0]  buf_wdata,
    output logic [`PE_OUT_AW-1:0]  out_raddr
);

    pe_pkg::wb_region_t      region;
    logic [`PE_WB_AW-3:0]    offset;
    logic                    req;
    logic                    wr_req;

    assign region = pe_pkg::wb_region_t'(wb_adr[`PE_WB_AW-1 -: 2]);
    assign offset = wb_adr[`PE_WB_AW-3:0];
    assign req    = wb_cyc && wb_stb && !wb_ack; // New access
    assign wr_req = req && wb_we;

    //////////////////////////////////////////////////////////////////////
    // Buffer ports
    assign if_we     = wr_req && (region == pe_pkg::IF_SPACE) && !busy;
    assign filt_we   = wr_req && (region == pe_pkg::FILT_SPACE) && !busy;
    assign buf_waddr = offset[`PE_IF_AW-1:0];
    assign buf_wdata = wb_dat_w[`PE_DATA_W-1:0];
    assign out_raddr = offset[`PE_OUT_AW-1:0]; // Read lands in the ack cycle

    //////////////////////////////////////////////////////////////////////
    // Ack and host registers
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_ack   <= 1'b0;
            start    <= 1'b0;
            mode     <= pe_pkg::MODE_CONV_S1;
            if_len   <= '0;
            filt_len <= '0;
        end else begin
            wb_ack <= req;
            start  <= 1'b0;
            if (wr_req && region == pe_pkg::REG_SPACE) begin
                case (offset)
                    `PE_REG_CTRL: begin
                        start <= wb_dat_w[0];
                        mode  <= pe_pkg::conv_mode_t'(wb_dat_w[2:1]);
                    end
                    `PE_REG_LEN: begin
                        if_len   <= wb_dat_w[`PE_LEN_W-1:0];
                        filt_len <= wb_dat_w[8 +: `PE_KLEN_W];
                    end
                    default: ;
                endcase
            end
        end
    end

    // Status or output buffer
    always_comb begin
        wb_dat_r = '0;
        if (region == pe_pkg::REG_SPACE && offset == `PE_REG_STATUS) begin
            wb_dat_r[0]              = busy;
            wb_dat_r[1]              = done;
            wb_dat_r[2]              = error;
            wb_dat_r[8 +: `PE_LEN_W] = out_count;
        end else if (region == pe_pkg::OUT_SPACE) begin
            wb_dat_r = {{(`PE_WB_DW-`PE_PSUM_W){out_rdata[`PE_PSUM_W-1]}}, out_rdata};
        end
    end

endmodule

//--- pe_top.sv
`timescale 1ns/1ps
`include "pe_config.svh"

module pe_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 wb_cyc,
    input  logic                 wb_stb,
    input  logic                 wb_we,
    input  logic [`PE_WB_AW-1:0] wb_adr,
    input  logic [`PE_WB_DW-1:0] wb_dat_w,
    output logic [`PE_WB_DW-1:0] wb_dat_r,
    output logic                 wb_ack
);

    // Host side
    logic                   start;
    pe_pkg::conv_mode_t     mode;
    logic [`PE_LEN_W-1:0]   if_len;
    logic [`PE_KLEN_W-1:0]  filt_len;
    logic                   if_we;
    logic                   filt_we;
    logic [`PE_IF_AW-1:0]   buf_waddr;
    logic [`PE_DATA_W-1:0]  buf_wdata;
    logic [`PE_OUT_AW-1:0]  out_raddr;
    logic [`PE_PSUM_W-1:0]  out_rdata;

    // Run control
    logic reset_all;
    logic read_start;
    logic start_rd_gen;
    logic clear_regs;
    logic busy;
    logic done;
    logic error;
    logic full_done;
    logic psum_done;

    // Datapath
    logic [`PE_IF_AW-1:0]   if_raddr;
    logic [`PE_FILT_AW-1:0] filt_raddr;
    logic [`PE_DATA_W-1:0]  if_rdata;
    logic [`PE_DATA_W-1:0]  filt_rdata;
    logic                   tap_valid;
    logic                   last_tap;
    logic [`PE_OUT_AW-1:0]  out_idx;
    logic [`PE_LEN_W-1:0]   out_count;
    logic                   out_we;
    logic [`PE_OUT_AW-1:0]  out_waddr;
    logic [`PE_PSUM_W-1:0]  out_wdata;

    pe_wb_regs u_wb_regs (
        .clk, .rst, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
        .busy, .done, .error, .out_count, .out_rdata,
        .start, .mode, .if_len, .filt_len, .if_we, .filt_we, .buf_waddr, .buf_wdata,
        .out_raddr
    );

    pe_controller u_controller (
        .clk, .rst, .start, .mode, .full_done, .psum_done,
        .empty_run (out_count == '0),
        .reset_all, .read_start, .start_rd_gen, .clear_regs, .busy, .done, .error
    );

    pe_addr_gen u_addr_gen (
        .clk, .rst, .reset_all, .read_start, .start_rd_gen, .mode, .if_len, .filt_len,
        .if_raddr, .filt_raddr, .tap_valid, .last_tap, .out_idx, .out_count, .full_done
    );

    pe_mac u_mac (
        .clk, .rst, .reset_all, .clear_regs, .mode, .tap_valid, .last_tap, .out_idx,
        .if_data (if_rdata), .filt_data (filt_rdata),
        .psum_done, .out_we, .out_waddr, .out_wdata
    );

    pe_scratchpad #(.DEPTH(`PE_IF_DEPTH), .WIDTH(`PE_DATA_W)) u_if_buf (
        .clk, .we (if_we), .waddr (buf_waddr), .wdata (buf_wdata),
        .raddr (if_raddr), .rdata (if_rdata)
    );

    pe_scratchpad #(.DEPTH(`PE_FILT_DEPTH), .WIDTH(`PE_DATA_W)) u_filt_buf (
        .clk, .we (filt_we), .waddr (buf_waddr[`PE_FILT_AW-1:0]), .wdata (buf_wdata),
        .raddr (filt_raddr), .rdata (filt_rdata)
    );

    pe_scratchpad #(.DEPTH(`PE_OUT_DEPTH), .WIDTH(`PE_PSUM_W)) u_out_buf (
        .clk, .we (out_we), .waddr (out_waddr), .wdata (out_wdata),
        .raddr (out_raddr), .rdata (out_rdata)
    );

endmodule

//--- pe_checker.sv
`timescale 1ns/1ps

module pe_checker (
    input logic                clk,
    input logic                rst,
    input pe_pkg::ctrl_state_t state,
    input logic                start_rd_gen,
    input logic                clear_regs,
    input logic                busy,
    input logic                done,
    input logic                wb_ack
);

    int   assert_fails = 0;
    logic working;

    assign working = (state == pe_pkg::ST_CONV_S1) || (state == pe_pkg::ST_CONV_S2) ||
                     (state == pe_pkg::ST_ADD);

    clear_in_work: assert property (@(posedge clk) disable iff (rst) clear_regs |-> working)
        else begin
            assert_fails++;
            $error("clear_regs raised outside a working state");
        end

    gen_in_dispatch: assert property (@(posedge clk) disable iff (rst)
                                      start_rd_gen |-> state == pe_pkg::ST_DISPATCH)
        else begin
            assert_fails++;
            $error("start_rd_gen raised outside ST_DISPATCH");
        end

    busy_xor_done: assert property (@(posedge clk) disable iff (rst) !(busy && done))
        else begin
            assert_fails++;
            $error("busy and done high together");
        end

    ack_one_cycle: assert property (@(posedge clk) disable iff (rst) wb_ack |=> !wb_ack)
        else begin
            assert_fails++;
            $error("wb_ack held for two cycles");
        end

endmodule

//--- tb_pe_top.sv
`timescale 1ns/1ps
`include "pe_config.svh"

module tb_pe_top;

    localparam int NT = 9;

    logic                 clk;
    logic                 rst;
    logic                 wb_cyc;
    logic                 wb_stb;
    logic                 wb_we;
    logic [`PE_WB_AW-1:0] wb_adr;
    logic [`PE_WB_DW-1:0] wb_dat_w;
    logic [`PE_WB_DW-1:0] wb_dat_r;
    logic                 wb_ack;

    // Per row: name, mode, N, K, rerun, expected count, expected error
    string t_name [NT] = '{"s1_k1", "s1_k3", "s1_kn", "s2_odd", "s2_even",
                           "bias", "bad_mode", "k_gt_n", "b2b"};
    int    t_mode [NT] = '{0, 0, 0, 1, 1, 2, 3, 0, 1};
    int    t_n    [NT] = '{8, 16, 6, 11, 12, 20, 8, 4, 9};
    int    t_k    [NT] = '{1, 3, 6, 4, 3, 3, 2, 6, 2};
    int    t_b2b  [NT] = '{0, 0, 0, 0, 0, 0, 0, 0, 1};
    int    t_cnt  [NT] = '{8, 14, 1, 4, 5, 20, 0, 0, 4};
    int    t_err  [NT] = '{0, 0, 0, 0, 0, 0, 1, 1, 0};

    logic signed [`PE_DATA_W-1:0] if_ref [`PE_IF_DEPTH];
    logic signed [`PE_DATA_W-1:0] filt_ref [`PE_FILT_DEPTH];
    int errors = 0;
    int passed = 0;
    int failed = 0;

    pe_top u_pe_top (
        .clk, .rst, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack
    );

    bind pe_top pe_checker u_checker (
        .clk (clk), .rst (rst), .state (u_controller.state), .start_rd_gen (start_rd_gen),
        .clear_regs (clear_regs), .busy (busy), .done (done), .wb_ack (wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Budget grows with the taps and bus traffic of every row
    initial begin : watchdog
        int budget;
        budget = 40;
        for (int r = 0; r < NT; r++) begin
            budget += (t_n[r] * t_k[r] + 6 * (t_n[r] + t_k[r]) + 60) * (t_b2b[r] + 1);
        end
        #(budget * 80);
        $display("Timeout: run did not finish within %0d ns", budget * 80);
        $display("Some tests failed");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // Bus access, held until the slave acks
    task automatic bus_cycle(input logic we, input logic [7:0] adr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
        @(posedge clk);
        #1;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdata;
        @(posedge clk);
        #1;
        while (!wb_ack) begin
            @(posedge clk);
            #1;
        end
        rdata  = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic check_outputs(input int r, inout int row_errs);
        logic [31:0] rd;
        int          stride;
        int          exp;
        stride = (t_mode[r] == 1) ? 2 : 1;
        for (int j = 0; j < t_cnt[r]; j++) begin
            exp = 0;
            if (t_mode[r] == 2) begin
                exp = if_ref[j] + filt_ref[0];
            end else begin
                for (int t = 0; t < t_k[r]; t++) begin
                    exp += if_ref[j * stride + t] * filt_ref[t];
                end
            end
            bus_cycle(1'b0, 8'hC0 + j, 32'd0, rd);
            if ($signed(rd) != exp) begin
                $display("Mismatch %s out[%0d]: expected %0d actual %0d",
                         t_name[r], j, exp, $signed(rd));
                row_errs++;
            end
        end
    endtask

    task automatic run_row(input int r);
        logic [31:0] st;
        int          row_errs;
        row_errs = 0;
        for (int i = 0; i < t_n[r]; i++) begin
            if_ref[i] = 8'($urandom);
            bus_cycle(1'b1, 8'h40 + i, {24'd0, if_ref[i]}, st);
        end
        for (int t = 0; t < t_k[r]; t++) begin
            filt_ref[t] = 8'($urandom);
            bus_cycle(1'b1, 8'h80 + t, {24'd0, filt_ref[t]}, st);
        end
        bus_cycle(1'b1, 8'h01, (t_k[r] << 8) | t_n[r], st);
        for (int p = 0; p <= t_b2b[r]; p++) begin
            if (p > 0) begin
                for (int i = 0; i < t_n[r]; i++) begin
                    if_ref[i] = 8'($urandom); // New IF data for the rerun
                    bus_cycle(1'b1, 8'h40 + i, {24'd0, if_ref[i]}, st);
                end
            end
            bus_cycle(1'b1, 8'h00, (t_mode[r] << 1) | 1, st);
            if (p == 0 && t_b2b[r] != 0) begin
                for (int i = 0; i < 3; i++) begin
                    bus_cycle(1'b1, 8'h40 + i, {24'd0, ~if_ref[i]}, st); // Dropped while busy
                end
            end
            if (p > 0) begin
                bus_cycle(1'b0, 8'h02, 32'd0, st);
                if (st[1] || !st[0]) begin
                    $display("Restart in %s did not clear done or raise busy", t_name[r]);
                    row_errs++;
                end
            end
            st = '0;
            while (!st[1]) begin
                bus_cycle(1'b0, 8'h02, 32'd0, st);
            end
            if (st[2] != t_err[r]) begin
                $display("Mismatch %s error: expected %0d actual %0d",
                         t_name[r], t_err[r], st[2]);
                row_errs++;
            end
            if (st[13:8] != t_cnt[r]) begin
                $display("Mismatch %s count: expected %0d actual %0d",
                         t_name[r], t_cnt[r], st[13:8]);
                row_errs++;
            end
            if (t_err[r] == 0) begin
                check_outputs(r, row_errs);
            end
        end
        if (row_errs == 0) begin
            passed++;
            $display("PASS %s", t_name[r]);
        end else begin
            failed++;
            $display("FAIL %s with %0d errors", t_name[r], row_errs);
        end
        errors += row_errs;
    endtask

    //////////////////////////////////////////////////////////////////////
    initial begin
        rst      = 1'b1;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        void'($urandom(32'h03735f6e));
        repeat (10) @(posedge clk);
        #1 rst = 1'b0;
        for (int r = 0; r < NT; r++) begin
            run_row(r);
        end
        errors += u_pe_top.u_checker.assert_fails;
        $display("Tests: %0d passed, %0d failed, %0d errors", passed, failed, errors);
        if (errors == 0 && failed == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- src.f
+incdir+.
pe_pkg.sv
pe_scratchpad.sv
pe_addr_gen.sv
pe_mac.sv
pe_controller.sv
pe_wb_regs.sv
pe_top.sv
pe_checker.sv
tb_pe_top.sv

//--- Bender.yml
package:
  name: pe_conv

sources:
  - include_dirs:
      - .
    files:
      - pe_pkg.sv
      - pe_scratchpad.sv
      - pe_addr_gen.sv
      - pe_mac.sv
      - pe_controller.sv
      - pe_wb_regs.sv
      - pe_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - pe_checker.sv
      - tb_pe_top.sv
